//--- hdl/dbus_pkg.sv
package dbus_pkg;

    // ------------------------------
    // Bus widths
    // ------------------------------
    localparam int XLEN        = 32;
    localparam int DBUS_ADDR_W = 32;

    // ------------------------------
    // Peripheral windows
    // ------------------------------
    // Offset bits inside one window, upper bits select the peripheral
    localparam int PERI_WIN_W = 16;

    localparam logic [DBUS_ADDR_W-1:0] CLINT_BASE = 32'h0200_0000;
    localparam logic [DBUS_ADDR_W-1:0] GPIO_BASE  = 32'h0300_0000;

    // Gpio register map, byte offsets in the gpio window
    localparam logic [PERI_WIN_W-1:0] GPIO_OUT_R = 16'h0000;
    localparam logic [PERI_WIN_W-1:0] GPIO_IN_R  = 16'h0004;

    // Number of gpio pins
    localparam int GPIO_W = 8;

endpackage

//--- hdl/clint_pkg.sv
package clint_pkg;

    // Offset width used inside the clint window
    localparam int CLINT_OFS_W = 16;

    // Full width of mtime and mtimecmp
    localparam int MTIME_W = 64;

    // Clint register map, byte offsets
    typedef enum logic [CLINT_OFS_W-1:0] {
        // Software interrupt pending
        MSIP_R          = 16'h0000,
        // Timer compare halves
        MTIMECMP_LOW_R  = 16'h4000,
        MTIMECMP_HIGH_R = 16'h4004,
        // Free-running timer halves
        MTIME_LOW_R     = 16'hBFF8,
        MTIME_HIGH_R    = 16'hBFFC
    } clint_reg_e;

endpackage

//--- hdl/dbus_if.sv
`timescale 1ns/1ps

interface dbus_if;
    import dbus_pkg::*;

    // Request, driven by the master
    logic [DBUS_ADDR_W-1:0] addr;
    logic [XLEN-1:0]        w_data;
    logic                   w_en;
    logic                   cyc;

    // Response, driven by the slave
    logic [XLEN-1:0]        r_data;
    logic                   ack;

    modport master (
        output addr, w_data, w_en, cyc,
        input  r_data, ack
    );

    // Mirror of master
    modport slave (
        input  addr, w_data, w_en, cyc,
        output r_data, ack
    );

endinterface

//--- hdl/dbus_decoder.sv
`timescale 1ns/1ps

module dbus_decoder (
    input  logic   clk,
    input  logic   rst_n,
    dbus_if.slave  host,
    dbus_if.master clint_bus,
    dbus_if.master gpio_bus
);
    import dbus_pkg::*;

    logic sel_clint;
    logic sel_gpio;
    logic sel_none;
    logic none_rd_ack_ff;

    // ------------------------------
    // Address decode
    // ------------------------------
    assign sel_clint = (host.addr[DBUS_ADDR_W-1:PERI_WIN_W] ==
                        CLINT_BASE[DBUS_ADDR_W-1:PERI_WIN_W]);
    assign sel_gpio  = (host.addr[DBUS_ADDR_W-1:PERI_WIN_W] ==
                        GPIO_BASE[DBUS_ADDR_W-1:PERI_WIN_W]);
    assign sel_none  = ~sel_clint & ~sel_gpio;

    // Request fans out to both, only cyc is steered
    assign clint_bus.addr   = host.addr;
    assign clint_bus.w_data = host.w_data;
    assign clint_bus.w_en   = host.w_en;
    assign clint_bus.cyc    = host.cyc & sel_clint;

    assign gpio_bus.addr    = host.addr;
    assign gpio_bus.w_data  = host.w_data;
    assign gpio_bus.w_en    = host.w_en;
    assign gpio_bus.cyc     = host.cyc & sel_gpio;

    // Unmapped reads, one-cycle registered ack like a real slave
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            none_rd_ack_ff <= 1'b0;
        end else begin
            none_rd_ack_ff <= sel_none & host.cyc & ~host.w_en & ~none_rd_ack_ff;
        end
    end

    // ------------------------------
    // Response mux
    // ------------------------------
    always_comb begin
        host.ack    = 1'b0;
        host.r_data = '0;
        if (sel_clint) begin
            host.ack    = clint_bus.ack;
            host.r_data = clint_bus.r_data;
        end else if (sel_gpio) begin
            host.ack    = gpio_bus.ack;
            host.r_data = gpio_bus.r_data;
        end else begin
            // Writes vanish, reads return zero
            host.ack    = (host.cyc & host.w_en) | none_rd_ack_ff;
        end
    end

    // Never two peripherals addressed together
    a_one_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({clint_bus.cyc, gpio_bus.cyc}));

endmodule

//--- hdl/clint.sv
`timescale 1ns/1ps

module clint (
    input  logic  clk,
    input  logic  rst_n,
    dbus_if.slave bus,
    output logic  clint_timer_irq_o,
    output logic  clint_soft_irq_o
);
    import dbus_pkg::*;
    import clint_pkg::*;

    clint_reg_e         reg_sel;
    logic               wr_req;
    logic               rd_req;
    logic [XLEN-1:0]    rd_data;
    logic [XLEN-1:0]    rd_data_ff;
    logic               rd_ack_ff;

    logic               mtime_lo_wr;
    logic               mtime_hi_wr;
    logic               mtimecmp_lo_wr;
    logic               mtimecmp_hi_wr;
    logic               msip_wr;

    logic [MTIME_W-1:0] mtime_ff;
    logic [MTIME_W-1:0] mtime_next;
    logic [MTIME_W-1:0] mtimecmp_ff;
    logic               msip_ff;
    logic               timer_irq_ff;

    // ------------------------------
    // Bus request decode
    // ------------------------------
    assign reg_sel = clint_reg_e'(bus.addr[CLINT_OFS_W-1:0]);
    assign wr_req  = bus.cyc & bus.w_en;
    assign rd_req  = bus.cyc & ~bus.w_en;

    always_comb begin
        mtime_lo_wr    = 1'b0;
        mtime_hi_wr    = 1'b0;
        mtimecmp_lo_wr = 1'b0;
        mtimecmp_hi_wr = 1'b0;
        msip_wr        = 1'b0;
        if (wr_req) begin
            case (reg_sel)
                MTIME_LOW_R:     mtime_lo_wr    = 1'b1;
                MTIME_HIGH_R:    mtime_hi_wr    = 1'b1;
                MTIMECMP_LOW_R:  mtimecmp_lo_wr = 1'b1;
                MTIMECMP_HIGH_R: mtimecmp_hi_wr = 1'b1;
                MSIP_R:          msip_wr        = 1'b1;
                default:         ;
            endcase
        end
    end

    // Read mux, unknown offsets read zero
    always_comb begin
        case (reg_sel)
            MTIME_LOW_R:     rd_data = mtime_ff[XLEN-1:0];
            MTIME_HIGH_R:    rd_data = mtime_ff[MTIME_W-1:XLEN];
            MTIMECMP_LOW_R:  rd_data = mtimecmp_ff[XLEN-1:0];
            MTIMECMP_HIGH_R: rd_data = mtimecmp_ff[MTIME_W-1:XLEN];
            MSIP_R:          rd_data = XLEN'(msip_ff);
            default:         rd_data = '0;
        endcase
    end

    // ------------------------------
    // Timer and compare registers
    // ------------------------------
    // A half write freezes the other half for that cycle
    always_comb begin
        mtime_next = mtime_ff + 1'b1;
        if (mtime_lo_wr) begin
            mtime_next = {mtime_ff[MTIME_W-1:XLEN], bus.w_data};
        end else if (mtime_hi_wr) begin
            mtime_next = {bus.w_data, mtime_ff[XLEN-1:0]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime_ff     <= '0;
            // All ones keeps the timer irq off
            mtimecmp_ff  <= '1;
            msip_ff      <= 1'b0;
            timer_irq_ff <= 1'b0;
        end else begin
            mtime_ff <= mtime_next;
            if (mtimecmp_lo_wr) begin
                mtimecmp_ff[XLEN-1:0] <= bus.w_data;
            end
            if (mtimecmp_hi_wr) begin
                mtimecmp_ff[MTIME_W-1:XLEN] <= bus.w_data;
            end
            if (msip_wr) begin
                msip_ff <= bus.w_data[0];
            end
            timer_irq_ff <= (mtime_ff >= mtimecmp_ff);
        end
    end

    // ------------------------------
    // Bus response
    // ------------------------------
    // Read data held only in the ack cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ack_ff  <= 1'b0;
            rd_data_ff <= '0;
        end else begin
            rd_ack_ff  <= rd_req & ~rd_ack_ff;
            rd_data_ff <= (rd_req & ~rd_ack_ff) ? rd_data : '0;
        end
    end

    assign bus.ack    = wr_req | rd_ack_ff;
    assign bus.r_data = rd_data_ff;

    assign clint_timer_irq_o = timer_irq_ff;
    assign clint_soft_irq_o  = msip_ff;

    // Read ack as seen on the bus lasts one cycle
    a_rd_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        (bus.ack && !bus.w_en) |=> !(bus.ack && !bus.w_en));

    // Reset value of mtimecmp must hold the irq off
    a_irq_low_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |=> !clint_timer_irq_o);

endmodule

//--- hdl/gpio.sv
`timescale 1ns/1ps

module gpio (
    input  logic                       clk,
    input  logic                       rst_n,
    dbus_if.slave                      bus,
    input  logic [dbus_pkg::GPIO_W-1:0] gpio_i,
    output logic [dbus_pkg::GPIO_W-1:0] gpio_o
);
    import dbus_pkg::*;

    logic [PERI_WIN_W-1:0] ofs;
    logic                  wr_req;
    logic                  rd_req;
    logic [GPIO_W-1:0]     out_ff;
    logic [GPIO_W-1:0]     sync1_ff;
    logic [GPIO_W-1:0]     sync2_ff;
    logic [XLEN-1:0]       rd_data;
    logic [XLEN-1:0]       rd_data_ff;
    logic                  rd_ack_ff;

    assign ofs    = bus.addr[PERI_WIN_W-1:0];
    assign wr_req = bus.cyc & bus.w_en;
    assign rd_req = bus.cyc & ~bus.w_en;

    // Output register and input synchronizer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_ff   <= '0;
            sync1_ff <= '0;
            sync2_ff <= '0;
        end else begin
            if (wr_req && ofs == GPIO_OUT_R) begin
                out_ff <= bus.w_data[GPIO_W-1:0];
            end
            sync1_ff <= gpio_i;
            sync2_ff <= sync1_ff;
        end
    end

    // Zero-extended register read
    always_comb begin
        rd_data = '0;
        if (ofs == GPIO_OUT_R) begin
            rd_data = XLEN'(out_ff);
        end else if (ofs == GPIO_IN_R) begin
            rd_data = XLEN'(sync2_ff);
        end
    end

    // Registered read, single-cycle ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ack_ff  <= 1'b0;
            rd_data_ff <= '0;
        end else begin
            rd_ack_ff  <= rd_req & ~rd_ack_ff;
            rd_data_ff <= (rd_req & ~rd_ack_ff) ? rd_data : '0;
        end
    end

    assign bus.ack    = wr_req | rd_ack_ff;
    assign bus.r_data = rd_data_ff;
    assign gpio_o     = out_ff;

endmodule

//--- hdl/periph_top.sv
`timescale 1ns/1ps

module periph_top (
    input  logic                            clk,
    input  logic                            rst_n,

    // Data bus, single master
    input  logic [dbus_pkg::DBUS_ADDR_W-1:0] dbus_addr_i,
    input  logic [dbus_pkg::XLEN-1:0]        dbus_w_data_i,
    input  logic                            dbus_w_en_i,
    input  logic                            dbus_cyc_i,
    output logic [dbus_pkg::XLEN-1:0]        dbus_r_data_o,
    output logic                            dbus_ack_o,

    // Gpio pins
    input  logic [dbus_pkg::GPIO_W-1:0]      gpio_i,
    output logic [dbus_pkg::GPIO_W-1:0]      gpio_o,

    // Interrupt lines toward the core
    output logic                            clint_timer_irq_o,
    output logic                            clint_soft_irq_o
);

    dbus_if host_bus ();
    dbus_if clint_bus ();
    dbus_if gpio_bus ();

    // Plain ports onto the upstream channel
    assign host_bus.addr   = dbus_addr_i;
    assign host_bus.w_data = dbus_w_data_i;
    assign host_bus.w_en   = dbus_w_en_i;
    assign host_bus.cyc    = dbus_cyc_i;
    assign dbus_r_data_o   = host_bus.r_data;
    assign dbus_ack_o      = host_bus.ack;

    dbus_decoder i_dbus_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .host      (host_bus.slave),
        .clint_bus (clint_bus.master),
        .gpio_bus  (gpio_bus.master)
    );

    clint i_clint (
        .clk               (clk),
        .rst_n             (rst_n),
        .bus               (clint_bus.slave),
        .clint_timer_irq_o (clint_timer_irq_o),
        .clint_soft_irq_o  (clint_soft_irq_o)
    );

    gpio i_gpio (
        .clk    (clk),
        .rst_n  (rst_n),
        .bus    (gpio_bus.slave),
        .gpio_i (gpio_i),
        .gpio_o (gpio_o)
    );

endmodule

//--- sim/periph_checker.sv
`timescale 1ns/1ps

module periph_checker (
    input  logic                              clk,
    input  logic                              rst_n,
    // Bus as seen on the DUT ports
    input  logic [dbus_pkg::DBUS_ADDR_W-1:0]  addr_i,
    input  logic                              cyc_i,
    input  logic                              w_en_i,
    input  logic                              ack_i,
    input  logic [dbus_pkg::XLEN-1:0]         r_data_i,
    input  logic                              timer_irq_i,
    input  logic                              soft_irq_i,
    input  logic [dbus_pkg::GPIO_W-1:0]       gpio_pins_i,
    // Expected values from the stimulus reader
    input  logic [1:0]                        rd_mode_i,
    input  logic [dbus_pkg::XLEN-1:0]         rd_lo_i,
    input  logic [dbus_pkg::XLEN-1:0]         rd_hi_i,
    input  logic                              lvl_chk_i,
    input  logic                              lvl_kind_i,
    input  logic [dbus_pkg::XLEN-1:0]         lvl_exp_i,
    output int                                data_errs_o,
    output int                                level_errs_o,
    output int                                ack_errs_o
);
    import dbus_pkg::*;

    localparam logic [1:0] MODE_RANGE = 2'd1;
    localparam logic [1:0] MODE_ABOVE = 2'd2;
    localparam int         ACK_LIMIT  = 8;

    int              data_errs    = 0;
    int              level_errs   = 0;
    int              ack_errs     = 0;
    int              wait_cnt     = 0;
    int              ack_lat      = 0;
    logic [XLEN-1:0] last_rd      = '0;

    // ------------------------------
    // Read data on the ack cycle
    // ------------------------------
    always @(posedge clk) begin
        if (rst_n && cyc_i && !w_en_i && ack_i) begin
            case (rd_mode_i)
                MODE_RANGE: begin
                    if ($isunknown(r_data_i) || r_data_i < rd_lo_i || r_data_i > rd_hi_i) begin
                        $display("** Error: dbus_r_data_o got 0x%08h expected 0x%08h to 0x%08h",
                                 r_data_i, rd_lo_i, rd_hi_i);
                        data_errs++;
                    end
                end
                MODE_ABOVE: begin
                    // Free-running counter must have moved on
                    if ($isunknown(r_data_i) || r_data_i <= last_rd) begin
                        $display("** Error: dbus_r_data_o got 0x%08h expected above 0x%08h",
                                 r_data_i, last_rd);
                        data_errs++;
                    end
                end
                default: begin
                    if (r_data_i !== rd_lo_i) begin
                        $display("** Error: dbus_r_data_o got 0x%08h expected 0x%08h",
                                 r_data_i, rd_lo_i);
                        data_errs++;
                    end
                end
            endcase
            last_rd = r_data_i;
        end
    end

    // ------------------------------
    // Ack timing
    // ------------------------------
    // Writes ack in the request cycle, reads one cycle later
    always @(posedge clk) begin
        if (!rst_n) begin
            wait_cnt = 0;
        end else if (!cyc_i) begin
            // No ack without a request
            if (ack_i !== 1'b0) begin
                $display("** Error: dbus_ack_o got 0x%0h expected 0x0 while idle", ack_i);
                ack_errs++;
            end
            wait_cnt = 0;
        end else if (ack_i) begin
            ack_lat = w_en_i ? 0 : 1;
            if (wait_cnt != ack_lat) begin
                $display("** Error: dbus_ack_o latency got 0x%0h expected 0x%0h",
                         wait_cnt, ack_lat);
                ack_errs++;
            end
            wait_cnt = 0;
        end else begin
            wait_cnt++;
            if (wait_cnt == ACK_LIMIT) begin
                $display("No acknowledge within %0d cycles for address 0x%08h",
                         ACK_LIMIT, addr_i);
                ack_errs++;
            end
        end
    end

    // ------------------------------
    // Pin levels on request
    // ------------------------------
    always @(posedge clk) begin
        if (rst_n && lvl_chk_i) begin
            if (lvl_kind_i) begin
                if (gpio_pins_i !== lvl_exp_i[GPIO_W-1:0]) begin
                    $display("** Error: gpio_o got 0x%02h expected 0x%02h",
                             gpio_pins_i, lvl_exp_i[GPIO_W-1:0]);
                    level_errs++;
                end
            end else begin
                // Timer in bit 1, soft in bit 0
                if (timer_irq_i !== lvl_exp_i[1]) begin
                    $display("** Error: clint_timer_irq_o got 0x%0h expected 0x%0h",
                             timer_irq_i, lvl_exp_i[1]);
                    level_errs++;
                end
                if (soft_irq_i !== lvl_exp_i[0]) begin
                    $display("** Error: clint_soft_irq_o got 0x%0h expected 0x%0h",
                             soft_irq_i, lvl_exp_i[0]);
                    level_errs++;
                end
            end
        end
    end

    assign data_errs_o  = data_errs;
    assign level_errs_o = level_errs;
    assign ack_errs_o   = ack_errs;

endmodule

//--- sim/tb_periph_top.sv
`timescale 1ns/1ps

module tb_periph_top;
    import dbus_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int ACK_LIMIT    = 8;
    localparam int MAX_OPS      = 128;
    localparam int WD_MARGIN    = 50;

    // Operation kinds, first column of the stimulus file
    localparam logic [31:0] OP_END      = 32'h0;
    localparam logic [31:0] OP_WRITE    = 32'h1;
    localparam logic [31:0] OP_READ     = 32'h2;
    localparam logic [31:0] OP_RANGE    = 32'h3;
    localparam logic [31:0] OP_ABOVE    = 32'h4;
    localparam logic [31:0] OP_WAIT     = 32'h5;
    localparam logic [31:0] OP_GPIO_SET = 32'h6;
    localparam logic [31:0] OP_IRQ_CHK  = 32'h7;
    localparam logic [31:0] OP_GPIO_CHK = 32'h8;

    // Read compare modes, same codes as in the checker
    localparam logic [1:0] MODE_EXACT = 2'd0;
    localparam logic [1:0] MODE_RANGE = 2'd1;
    localparam logic [1:0] MODE_ABOVE = 2'd2;

    logic                   clk;
    logic                   rst_n;
    logic [DBUS_ADDR_W-1:0] dbus_addr;
    logic [XLEN-1:0]        dbus_w_data;
    logic                   dbus_w_en;
    logic                   dbus_cyc;
    logic [XLEN-1:0]        dbus_r_data;
    logic                   dbus_ack;
    logic [GPIO_W-1:0]      gpio_in;
    logic [GPIO_W-1:0]      gpio_out;
    logic                   timer_irq;
    logic                   soft_irq;

    // Expected values for the checker
    logic [1:0]             rd_mode;
    logic [XLEN-1:0]        rd_lo;
    logic [XLEN-1:0]        rd_hi;
    logic                   lvl_chk;
    logic                   lvl_kind;
    logic [XLEN-1:0]        lvl_exp;
    int                     data_errs;
    int                     level_errs;
    int                     ack_errs;
    int                     stim_errs = 0;

    // Four words per operation
    logic [31:0]            stim_mem [0:4*MAX_OPS-1];
    int                     n_ops;
    int                     wd_cycles;
    logic                   wd_armed = 1'b0;

    periph_top i_dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .dbus_addr_i       (dbus_addr),
        .dbus_w_data_i     (dbus_w_data),
        .dbus_w_en_i       (dbus_w_en),
        .dbus_cyc_i        (dbus_cyc),
        .dbus_r_data_o     (dbus_r_data),
        .dbus_ack_o        (dbus_ack),
        .gpio_i            (gpio_in),
        .gpio_o            (gpio_out),
        .clint_timer_irq_o (timer_irq),
        .clint_soft_irq_o  (soft_irq)
    );

    periph_checker i_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .addr_i         (dbus_addr),
        .cyc_i          (dbus_cyc),
        .w_en_i         (dbus_w_en),
        .ack_i          (dbus_ack),
        .r_data_i       (dbus_r_data),
        .timer_irq_i    (timer_irq),
        .soft_irq_i     (soft_irq),
        .gpio_pins_i    (gpio_out),
        .rd_mode_i      (rd_mode),
        .rd_lo_i        (rd_lo),
        .rd_hi_i        (rd_hi),
        .lvl_chk_i      (lvl_chk),
        .lvl_kind_i     (lvl_kind),
        .lvl_exp_i      (lvl_exp),
        .data_errs_o    (data_errs),
        .level_errs_o   (level_errs),
        .ack_errs_o     (ack_errs)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // ------------------------------
    // Bus master
    // ------------------------------
    // Called on a falling edge, returns on a falling edge after one idle cycle
    task automatic bus_access(input logic we, input logic [DBUS_ADDR_W-1:0] addr,
                              input logic [XLEN-1:0] data);
        int   waited;
        logic seen;
        dbus_addr   = addr;
        dbus_w_data = data;
        dbus_w_en   = we;
        dbus_cyc    = 1'b1;
        waited      = 0;
        seen        = 1'b0;
        // Hold the request until ack, bounded by the ack limit
        while (!seen && waited < ACK_LIMIT) begin
            @(posedge clk);
            waited++;
            if (dbus_ack) begin
                seen = 1'b1;
            end
        end
        @(negedge clk);
        dbus_cyc  = 1'b0;
        dbus_w_en = 1'b0;
        @(negedge clk);
    endtask

    // One-cycle strobe, checker samples it on the rising edge
    task automatic request_level_check(input logic kind, input logic [XLEN-1:0] exp_val);
        lvl_kind = kind;
        lvl_exp  = exp_val;
        lvl_chk  = 1'b1;
        @(negedge clk);
        lvl_chk  = 1'b0;
    endtask

    task automatic run_op(input logic [31:0] kind, input logic [31:0] addr,
                          input logic [31:0] data, input logic [31:0] exp_val);
        case (kind)
            OP_WRITE: begin
                bus_access(1'b1, addr, data);
            end
            OP_READ: begin
                rd_mode = MODE_EXACT;
                rd_lo   = exp_val;
                rd_hi   = exp_val;
                bus_access(1'b0, addr, '0);
            end
            OP_RANGE: begin
                // Lower bound in data, span in the last column
                rd_mode = MODE_RANGE;
                rd_lo   = data;
                rd_hi   = data + exp_val;
                bus_access(1'b0, addr, '0);
            end
            OP_ABOVE: begin
                rd_mode = MODE_ABOVE;
                bus_access(1'b0, addr, '0);
            end
            OP_WAIT: begin
                repeat (data) @(negedge clk);
            end
            OP_GPIO_SET: begin
                gpio_in = data[GPIO_W-1:0];
                @(negedge clk);
            end
            OP_IRQ_CHK: begin
                request_level_check(1'b0, exp_val);
            end
            OP_GPIO_CHK: begin
                request_level_check(1'b1, exp_val);
            end
            default: begin
                $display("Unknown operation kind 0x%0h in the stimulus file", kind);
                stim_errs++;
            end
        endcase
    endtask

    // ------------------------------
    // Stimulus reader
    // ------------------------------
    initial begin
        int idx;
        int line_cost;
        int max_cost;
        int total;
        rst_n       = 1'b0;
        dbus_addr   = '0;
        dbus_w_data = '0;
        dbus_w_en   = 1'b0;
        dbus_cyc    = 1'b0;
        gpio_in     = '0;
        rd_mode     = MODE_EXACT;
        rd_lo       = '0;
        rd_hi       = '0;
        lvl_chk     = 1'b0;
        lvl_kind    = 1'b0;
        lvl_exp     = '0;

        $readmemh("sim/periph_stimulus.txt", stim_mem);

        // Count lines up to the end marker, worst-case cycles per line
        max_cost = ACK_LIMIT + 2;
        n_ops    = 0;
        while (n_ops < MAX_OPS && !$isunknown(stim_mem[4*n_ops])
               && stim_mem[4*n_ops] != OP_END) begin
            if (stim_mem[4*n_ops] == OP_WAIT) begin
                line_cost = int'(stim_mem[4*n_ops+2]) + 1;
                if (line_cost > max_cost) begin
                    max_cost = line_cost;
                end
            end
            n_ops++;
        end
        if (n_ops == 0) begin
            $display("The stimulus file holds no operations");
            stim_errs++;
        end
        wd_cycles = n_ops * max_cost + RESET_CYCLES + WD_MARGIN;
        wd_armed  = 1'b1;

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        for (idx = 0; idx < n_ops; idx++) begin
            run_op(stim_mem[4*idx], stim_mem[4*idx+1], stim_mem[4*idx+2],
                   stim_mem[4*idx+3]);
        end
        repeat (2) @(negedge clk);

        total = data_errs + level_errs + ack_errs + stim_errs;
        $write("%0d operations, %0d data errors, ", n_ops, data_errs);
        $display("%0d level errors, %0d ack errors, %0d stimulus errors",
                 level_errs, ack_errs, stim_errs);
        if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog, armed once the file length is known
    initial begin
        wait (wd_armed);
        #(wd_cycles * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the stimulus did not finish", wd_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- sim/periph_stimulus.txt
// Columns are kind, address, data and expected value, all in hex
// Kind 1 write, 2 read, 3 read within data to data plus expected, 4 read above previous read
// Kind 5 wait data cycles, 6 drive gpio_i, 7 irq levels as timer bit 1 and soft bit 0
// Kind 8 gpio_o level, 0 end
// mtimecmp halves, each write keeps the other half
1 02004000 12345678 0
2 02004004 0 ffffffff
1 02004004 9abcdef0 0
2 02004000 0 12345678
2 02004004 0 9abcdef0
// mtime counting and upper word
1 0200bffc 00000000 0
1 0200bff8 00001000 0
3 0200bff8 00001000 00000020
4 0200bff8 0 0
1 0200bffc 00000005 0
2 0200bffc 0 00000005
// Timer irq with compare at all ones, then a few counts ahead
1 02004004 ffffffff 0
1 02004000 ffffffff 0
7 0 0 0
1 0200bffc 00000000 0
1 0200bff8 00002000 0
1 02004000 00002040 0
1 02004004 00000000 0
7 0 0 0
5 0 00000050 0
7 0 0 00000002
1 02004004 ffffffff 0
5 0 00000002 0
7 0 0 0
// Software irq
1 02000000 00000001 0
7 0 0 00000001
2 02000000 0 00000001
1 02000000 00000000 0
7 0 0 0
2 02000000 0 00000000
// gpio output and synchronized input
1 03000000 000000a5 0
8 0 0 000000a5
2 03000000 0 000000a5
6 0 0000003c 0
5 0 00000003 0
2 03000004 0 0000003c
// Unmapped window, low bits aliasing mtimecmp
2 04004000 0 00000000
1 04004000 deadbeef 0
2 02004000 0 00002040
2 02004004 0 ffffffff
0 0 0 0

//--- tb.f
hdl/dbus_pkg.sv
hdl/clint_pkg.sv
hdl/dbus_if.sv
hdl/dbus_decoder.sv
hdl/clint.sv
hdl/gpio.sv
hdl/periph_top.sv
sim/periph_checker.sv
sim/tb_periph_top.sv

//--- Makefile
# Verilator flow for the peripheral block testbench

VERILATOR ?= verilator
TOP       ?= tb_periph_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation passed
FAIL_MSG  ?= Simulation failed

SOURCES := $(wildcard hdl/*.sv sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
